// ==== fpm_pkg.sv ====
package fpm_pkg;

	// datapath widths
	localparam int FPM_EXP_W = 8;
	localparam int FPM_SUM_W = 10;
	localparam int FPM_SHIFT_W = 6;

	// smaller operand falls off the mantissa at this distance
	localparam int FPM_ALIGN_LIMIT = 40;

	// apb register offsets
	localparam logic [3:0] FPM_ADDR_OPERANDS = 4'h0;
	localparam logic [3:0] FPM_ADDR_CONTROL = 4'h4;
	localparam logic [3:0] FPM_ADDR_STATUS = 4'h8;
	localparam logic [3:0] FPM_ADDR_RESULT = 4'hc;

	// fixed-point group 0..3, floating group 4..7
	typedef enum logic [2:0] {
		ad = 3'd0,
		sd = 3'd1,
		mw = 3'd2,
		dw = 3'd3,
		af = 3'd4,
		sf = 3'd5,
		mf = 3'd6,
		df = 3'd7
	} fpm_opcode_e;

	typedef struct packed {
		logic af;
		logic sf;
		logic mf;
		logic df;
		logic illegal;
	} fpm_op_t;

	typedef struct packed {
		logic [FPM_EXP_W-1:0] ea;
		logic [FPM_EXP_W-1:0] eb;
		fpm_opcode_e op;
	} fpm_cmd_t;

	typedef struct packed {
		logic [FPM_EXP_W-1:0] exponent;
		logic [FPM_SHIFT_W-1:0] shift;
		logic g;
		logic v;
		logic u;
		logic illegal;
	} fpm_result_t;

	// busy lands in bit 0 of the status word
	typedef struct packed {
		logic illegal;
		logic u;
		logic v;
		logic g;
		logic done;
		logic busy;
	} fpm_status_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [3:0] paddr;
		logic [31:0] pwdata;
	} fpm_apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic pready;
		logic pslverr;
	} fpm_apb_rsp_t;

endpackage

// ==== fpm_opcode_decoder.sv ====
`timescale 1ns/100ps

module fpm_opcode_decoder (
	input fpm_pkg::fpm_opcode_e op,
	output fpm_pkg::fpm_op_t dec
);

	// one flag per floating op, fixed-point group only marks illegal
	always_comb begin
		dec = '0;
		case (op)
			fpm_pkg::af: begin
				dec.af = 1'b1;
			end
			fpm_pkg::sf: begin
				dec.sf = 1'b1;
			end
			fpm_pkg::mf: begin
				dec.mf = 1'b1;
			end
			fpm_pkg::df: begin
				dec.df = 1'b1;
			end
			fpm_pkg::ad,
			fpm_pkg::sd,
			fpm_pkg::mw,
			fpm_pkg::dw: begin
				dec.illegal = 1'b1;
			end
			default: begin
				dec.illegal = 1'b1;
			end
		endcase
	end

endmodule

// ==== fpm_exponent_adder.sv ====
`timescale 1ns/100ps

module fpm_exponent_adder (
	input logic f2strob,
	input logic _0_d_,
	input logic load,
	input logic [fpm_pkg::FPM_EXP_W-1:0] ea,
	input logic [fpm_pkg::FPM_EXP_W-1:0] eb,
	input fpm_pkg::fpm_op_t dec,
	output logic [fpm_pkg::FPM_SUM_W-1:0] sum,
	output logic ge_limit
);

	// operand register and delayed copy
	logic [fpm_pkg::FPM_EXP_W-1:0] d_q;
	logic [fpm_pkg::FPM_EXP_W-1:0] dl_q;

	// second adder input after complement/force selection
	logic [fpm_pkg::FPM_EXP_W-1:0] dsum;
	logic cin;

	logic [fpm_pkg::FPM_SUM_W-1:0] d_ext;
	logic [fpm_pkg::FPM_SUM_W-1:0] dsum_ext;

	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			d_q <= '0;
			dl_q <= '0;
		end else if (load) begin
			d_q <= ea;
			dl_q <= eb;
		end
	end

	// mf adds the true operand, everything else subtracts
	always_comb begin
		if (dec.mf) begin
			dsum = dl_q;
			cin = 1'b0;
		end else begin
			dsum = ~dl_q;
			cin = 1'b1;
		end
	end

	// two extension bits, sign copies of each input
	assign d_ext = {
		{(fpm_pkg::FPM_SUM_W - fpm_pkg::FPM_EXP_W){d_q[fpm_pkg::FPM_EXP_W-1]}},
		d_q
	};
	assign dsum_ext = {
		{(fpm_pkg::FPM_SUM_W - fpm_pkg::FPM_EXP_W){dsum[fpm_pkg::FPM_EXP_W-1]}},
		dsum
	};

	assign sum = d_ext + dsum_ext + {{(fpm_pkg::FPM_SUM_W-1){1'b0}}, cin};

	// |diff| >= 40 on either side
	always_comb begin
		ge_limit = 1'b0;
		if ($signed(sum) >= fpm_pkg::FPM_ALIGN_LIMIT) begin
			ge_limit = 1'b1;
		end
		if ($signed(sum) <= -fpm_pkg::FPM_ALIGN_LIMIT) begin
			ge_limit = 1'b1;
		end
	end

endmodule

// ==== fpm_shift_counter.sv ====
`timescale 1ns/100ps

module fpm_shift_counter (
	input logic f2strob,
	input logic _0_d_,
	input logic load,
	input logic [fpm_pkg::FPM_SHIFT_W-1:0] value,
	output logic zero
);

	logic [fpm_pkg::FPM_SHIFT_W-1:0] cnt;

	// load wins, then count down and park at zero
	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			cnt <= '0;
		end else if (load) begin
			cnt <= value;
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end
	end

	// true on the step that reaches zero and while parked there,
	// so the sequencer can leave align on that same edge
	assign zero = ~|cnt[fpm_pkg::FPM_SHIFT_W-1:1];

endmodule

// ==== fpm_sequencer.sv ====
`timescale 1ns/100ps

module fpm_sequencer (
	input logic f2strob,
	input logic _0_d_,
	input logic start,
	input fpm_pkg::fpm_cmd_t cmd,
	input fpm_pkg::fpm_op_t dec,
	input logic [fpm_pkg::FPM_SUM_W-1:0] sum,
	input logic ge_limit,
	input logic zero,
	output logic adder_load,
	output logic cnt_load,
	output logic [fpm_pkg::FPM_SHIFT_W-1:0] cnt_value,
	output fpm_pkg::fpm_status_t status,
	output fpm_pkg::fpm_result_t result
);

	typedef enum logic [1:0] {
		st_idle,
		st_load,
		st_sum,
		st_align
	} state_e;

	state_e state;
	logic busy;
	logic done;

	fpm_pkg::fpm_result_t res_n;
	logic [fpm_pkg::FPM_SUM_W-1:0] mag;
	logic [fpm_pkg::FPM_SHIFT_W-1:0] shift_n;
	logic diff_neg;
	logic ovf;
	logic unf;
	logic align_op;

	assign align_op = dec.af | dec.sf;
	assign diff_neg = sum[fpm_pkg::FPM_SUM_W-1];
	assign mag = diff_neg ? -sum : sum;

	// saturate alignment count at the limit
	assign shift_n = ge_limit ?
		fpm_pkg::FPM_ALIGN_LIMIT[fpm_pkg::FPM_SHIFT_W-1:0] :
		mag[fpm_pkg::FPM_SHIFT_W-1:0];

	// above 127 / below -128 from the extension bits and sign
	assign ovf = ~sum[fpm_pkg::FPM_SUM_W-1] &
		(sum[fpm_pkg::FPM_SUM_W-2] | sum[fpm_pkg::FPM_EXP_W-1]);
	assign unf = sum[fpm_pkg::FPM_SUM_W-1] &
		~(sum[fpm_pkg::FPM_SUM_W-2] & sum[fpm_pkg::FPM_EXP_W-1]);

	always_comb begin
		res_n = '0;
		if (align_op) begin
			// larger exponent wins
			res_n.exponent = diff_neg ? cmd.eb : cmd.ea;
			res_n.shift = shift_n;
			res_n.g = ge_limit;
		end else if (dec.mf || dec.df) begin
			res_n.exponent = sum[fpm_pkg::FPM_EXP_W-1:0];
			res_n.v = ovf;
			res_n.u = unf;
		end else begin
			res_n.exponent = result.exponent;
			res_n.shift = result.shift;
			res_n.illegal = 1'b1;
		end
	end

	assign adder_load = (state == st_load);
	assign cnt_load = (state == st_sum) & align_op;
	assign cnt_value = shift_n;

	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			state <= st_idle;
			busy <= 1'b0;
			done <= 1'b0;
			result <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (start) begin
						state <= st_load;
						busy <= 1'b1;
						done <= 1'b0;
					end
				end
				st_load: begin
					state <= st_sum;
				end
				st_sum: begin
					result <= res_n;
					if (align_op && shift_n != '0) begin
						state <= st_align;
					end else begin
						state <= st_idle;
						busy <= 1'b0;
						done <= 1'b1;
					end
				end
				st_align: begin
					if (zero) begin
						state <= st_idle;
						busy <= 1'b0;
						done <= 1'b1;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	assign status.busy = busy;
	assign status.done = done;
	assign status.g = result.g;
	assign status.v = result.v;
	assign status.u = result.u;
	assign status.illegal = result.illegal;

endmodule

// ==== fpm_apb_regs.sv ====
`timescale 1ns/100ps

module fpm_apb_regs (
	input logic f2strob,
	input logic _0_d_,
	input fpm_pkg::fpm_apb_req_t apb_req,
	output fpm_pkg::fpm_apb_rsp_t apb_rsp,
	input fpm_pkg::fpm_status_t status,
	input fpm_pkg::fpm_result_t result,
	output logic start,
	output fpm_pkg::fpm_cmd_t cmd
);

	logic access;
	logic wr;
	logic rd;
	logic sel_operands;
	logic sel_control;
	logic sel_status;
	logic sel_result;
	logic mapped;
	logic busy;
	logic ctrl_err;

	logic [fpm_pkg::FPM_EXP_W-1:0] ea_q;
	logic [fpm_pkg::FPM_EXP_W-1:0] eb_q;

	assign access = apb_req.psel & apb_req.penable;
	assign wr = access & apb_req.pwrite;
	assign rd = access & ~apb_req.pwrite;

	assign sel_operands = (apb_req.paddr == fpm_pkg::FPM_ADDR_OPERANDS);
	assign sel_control = (apb_req.paddr == fpm_pkg::FPM_ADDR_CONTROL);
	assign sel_status = (apb_req.paddr == fpm_pkg::FPM_ADDR_STATUS);
	assign sel_result = (apb_req.paddr == fpm_pkg::FPM_ADDR_RESULT);
	assign mapped = sel_operands | sel_control | sel_status | sel_result;

	// pending start counts as busy until the sequencer picks it up
	assign busy = status.busy | start;
	assign ctrl_err = wr & sel_control & busy;

	assign apb_rsp.pready = 1'b1;
	assign apb_rsp.pslverr = access & (~mapped | ctrl_err);

	always_comb begin
		apb_rsp.prdata = '0;
		if (rd) begin
			if (sel_operands) begin
				apb_rsp.prdata = {16'd0, eb_q, ea_q};
			end else if (sel_control) begin
				apb_rsp.prdata = {29'd0, cmd.op};
			end else if (sel_status) begin
				apb_rsp.prdata = {26'd0, status};
			end else if (sel_result) begin
				apb_rsp.prdata = {12'd0, result.illegal, result.u, result.v, result.g,
					2'd0, result.shift, result.exponent};
			end
		end
	end

	// command snapshot taken with the accepted control write
	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			ea_q <= '0;
			eb_q <= '0;
			cmd <= '0;
			start <= 1'b0;
		end else begin
			start <= 1'b0;
			if (wr && sel_operands) begin
				ea_q <= apb_req.pwdata[7:0];
				eb_q <= apb_req.pwdata[15:8];
			end
			if (wr && sel_control && !busy) begin
				cmd.ea <= ea_q;
				cmd.eb <= eb_q;
				cmd.op <= fpm_pkg::fpm_opcode_e'(apb_req.pwdata[2:0]);
				start <= 1'b1;
			end
		end
	end

endmodule

// ==== fpm_top.sv ====
`timescale 1ns/100ps

module fpm_top (
	input logic f2strob,
	input logic _0_d_,
	input fpm_pkg::fpm_apb_req_t apb_req,
	output fpm_pkg::fpm_apb_rsp_t apb_rsp
);

	fpm_pkg::fpm_status_t status;
	fpm_pkg::fpm_result_t result;
	fpm_pkg::fpm_cmd_t cmd;
	fpm_pkg::fpm_op_t dec;
	logic start;
	logic adder_load;
	logic [fpm_pkg::FPM_SUM_W-1:0] sum;
	logic ge_limit;
	logic cnt_load;
	logic [fpm_pkg::FPM_SHIFT_W-1:0] cnt_value;
	logic zero;

	fpm_apb_regs regs_i (
		.f2strob(f2strob),
		._0_d_(_0_d_),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.status(status),
		.result(result),
		.start(start),
		.cmd(cmd)
	);

	fpm_opcode_decoder dec_i (
		.op(cmd.op),
		.dec(dec)
	);

	fpm_exponent_adder adder_i (
		.f2strob(f2strob),
		._0_d_(_0_d_),
		.load(adder_load),
		.ea(cmd.ea),
		.eb(cmd.eb),
		.dec(dec),
		.sum(sum),
		.ge_limit(ge_limit)
	);

	fpm_shift_counter cnt_i (
		.f2strob(f2strob),
		._0_d_(_0_d_),
		.load(cnt_load),
		.value(cnt_value),
		.zero(zero)
	);

	fpm_sequencer seq_i (
		.f2strob(f2strob),
		._0_d_(_0_d_),
		.start(start),
		.cmd(cmd),
		.dec(dec),
		.sum(sum),
		.ge_limit(ge_limit),
		.zero(zero),
		.adder_load(adder_load),
		.cnt_load(cnt_load),
		.cnt_value(cnt_value),
		.status(status),
		.result(result)
	);

endmodule

// ==== tb_fpm.sv ====
`timescale 1ns/100ps

module tb_fpm;

	localparam int APB_TIMEOUT = 16;
	localparam int DONE_TIMEOUT = 100;

	logic f2strob;
	logic _0_d_;
	fpm_pkg::fpm_apb_req_t apb_req;
	fpm_pkg::fpm_apb_rsp_t apb_rsp;

	// running model state between operations
	fpm_pkg::fpm_result_t model_result;
	fpm_pkg::fpm_cmd_t last_cmd;

	fpm_top dut_i (
		.f2strob(f2strob),
		._0_d_(_0_d_),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp)
	);

	always #5 f2strob = ~f2strob;

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1);
	endtask

	// setup and access phase on falling edges, response sampled mid low phase
	task automatic apb_xfer(input logic write, input logic [3:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic slverr);
		int waited;
		logic ready;
		waited = 0;
		ready = 1'b0;
		@(negedge f2strob);
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = write;
		apb_req.paddr = addr;
		apb_req.pwdata = wdata;
		@(negedge f2strob);
		apb_req.penable = 1'b1;
		while (!ready) begin
			#2;
			if (apb_rsp.pready) begin
				ready = 1'b1;
				rdata = apb_rsp.prdata;
				slverr = apb_rsp.pslverr;
			end else if (waited == APB_TIMEOUT) begin
				stop_run("APB transfer timed out waiting for pready");
			end
			waited++;
			@(negedge f2strob);
		end
		apb_req = '0;
	endtask

	task automatic reg_write(input logic [3:0] addr, input logic [31:0] data, input logic exp_err);
		logic [31:0] rdata;
		logic slverr;
		apb_xfer(1'b1, addr, data, rdata, slverr);
		if (slverr !== exp_err) begin
			stop_run($sformatf("write to address 0x%h gave pslverr %b but %b was expected",
				addr, slverr, exp_err));
		end
	endtask

	task automatic reg_read(input logic [3:0] addr, output logic [31:0] data, input logic exp_err);
		logic slverr;
		apb_xfer(1'b0, addr, 32'd0, data, slverr);
		if (slverr !== exp_err) begin
			stop_run($sformatf("read from address 0x%h gave pslverr %b but %b was expected",
				addr, slverr, exp_err));
		end
	endtask

	function automatic fpm_pkg::fpm_result_t unpack_result(input logic [31:0] word);
		fpm_pkg::fpm_result_t r;
		r.exponent = word[7:0];
		r.shift = word[13:8];
		r.g = word[16];
		r.v = word[17];
		r.u = word[18];
		r.illegal = word[19];
		return r;
	endfunction

	// expected result from the exponent rules of each floating op
	function automatic fpm_pkg::fpm_result_t fpm_ref(input fpm_pkg::fpm_cmd_t cmd,
		input fpm_pkg::fpm_result_t prev);
		fpm_pkg::fpm_result_t r;
		int a;
		int b;
		int full;
		int mag;
		r = '0;
		a = $signed(cmd.ea);
		b = $signed(cmd.eb);
		case (cmd.op)
			fpm_pkg::af, fpm_pkg::sf: begin
				mag = (a >= b) ? a - b : b - a;
				r.exponent = (a >= b) ? cmd.ea : cmd.eb;
				r.g = (mag >= fpm_pkg::FPM_ALIGN_LIMIT);
				full = r.g ? fpm_pkg::FPM_ALIGN_LIMIT : mag;
				r.shift = full[5:0];
			end
			fpm_pkg::mf, fpm_pkg::df: begin
				full = (cmd.op == fpm_pkg::mf) ? a + b : a - b;
				r.exponent = full[7:0];
				r.v = (full > 127);
				r.u = (full < -128);
			end
			default: begin
				r.exponent = prev.exponent;
				r.shift = prev.shift;
				r.illegal = 1'b1;
			end
		endcase
		return r;
	endfunction

	task automatic check_result(input fpm_pkg::fpm_result_t got, input fpm_pkg::fpm_result_t exp);
		if (got !== exp) begin
			stop_run($sformatf(
				"MISMATCH result: got 0x%05h expected 0x%05h (ea 0x%02h eb 0x%02h op %0d)",
				got, exp, last_cmd.ea, last_cmd.eb, last_cmd.op));
		end
	endtask

	task automatic check_status(input fpm_pkg::fpm_status_t got, input fpm_pkg::fpm_status_t exp);
		if (got !== exp) begin
			stop_run($sformatf(
				"MISMATCH status: got 0x%02h expected 0x%02h (ea 0x%02h eb 0x%02h op %0d)",
				got, exp, last_cmd.ea, last_cmd.eb, last_cmd.op));
		end
	endtask

	// poll until the unit reports done, then compare status and result
	task automatic check_operation(input fpm_pkg::fpm_result_t exp);
		logic [31:0] word;
		fpm_pkg::fpm_status_t st;
		fpm_pkg::fpm_status_t exp_st;
		int polls;
		polls = 0;
		st = '0;
		while (!(st.done && !st.busy)) begin
			if (polls == DONE_TIMEOUT) begin
				stop_run("operation never finished, done did not rise");
			end
			polls++;
			reg_read(fpm_pkg::FPM_ADDR_STATUS, word, 1'b0);
			st = word[5:0];
		end
		exp_st = '0;
		exp_st.done = 1'b1;
		exp_st.g = exp.g;
		exp_st.v = exp.v;
		exp_st.u = exp.u;
		exp_st.illegal = exp.illegal;
		check_status(st, exp_st);
		reg_read(fpm_pkg::FPM_ADDR_RESULT, word, 1'b0);
		check_result(unpack_result(word), exp);
	endtask

	task automatic start_op(input logic [7:0] ea, input logic [7:0] eb,
		input fpm_pkg::fpm_opcode_e op);
		reg_write(fpm_pkg::FPM_ADDR_OPERANDS, {16'd0, eb, ea}, 1'b0);
		reg_write(fpm_pkg::FPM_ADDR_CONTROL, {29'd0, op}, 1'b0);
		last_cmd.ea = ea;
		last_cmd.eb = eb;
		last_cmd.op = op;
	endtask

	task automatic run_op(input logic [7:0] ea, input logic [7:0] eb,
		input fpm_pkg::fpm_opcode_e op);
		fpm_pkg::fpm_result_t exp;
		start_op(ea, eb, op);
		exp = fpm_ref(last_cmd, model_result);
		check_operation(exp);
		model_result = exp;
	endtask

	initial begin
		logic [31:0] word;
		logic [7:0] a;
		logic [7:0] b;
		int d;
		fpm_pkg::fpm_status_t st;
		fpm_pkg::fpm_result_t exp;
		logic [7:0] edge_vals [5];
		logic [7:0] far_a [5];
		logic [7:0] far_b [5];
		f2strob = 1'b0;
		_0_d_ = 1'b0;
		apb_req = '0;
		model_result = '0;
		last_cmd = '0;
		void'($urandom(32'hacbcdcd0));
		edge_vals = '{8'h7f, 8'h80, 8'h00, 8'h01, 8'hff};
		// distances 39, 40, 41, 100, 255
		far_a = '{8'h0a, 8'h14, 8'h15, 8'h64, 8'h7f};
		far_b = '{8'he3, 8'hec, 8'hec, 8'h00, 8'h80};
		repeat (8) @(posedge f2strob);
		@(negedge f2strob);
		_0_d_ = 1'b1;

		reg_read(fpm_pkg::FPM_ADDR_STATUS, word, 1'b0);
		st = word[5:0];
		check_status(st, '0);
		reg_read(fpm_pkg::FPM_ADDR_RESULT, word, 1'b0);
		check_result(unpack_result(word), '0);

		// mf and df at the range limits, then random
		foreach (edge_vals[i]) begin
			foreach (edge_vals[j]) begin
				run_op(edge_vals[i], edge_vals[j], fpm_pkg::mf);
				run_op(edge_vals[i], edge_vals[j], fpm_pkg::df);
			end
		end
		repeat (20) begin
			run_op(8'($urandom), 8'($urandom), ($urandom & 1) ? fpm_pkg::mf : fpm_pkg::df);
		end

		// alignment distance below the limit, both signs
		repeat (20) begin
			a = 8'($urandom);
			d = $urandom_range(39, 0);
			if ($signed(a) - d >= -128) begin
				b = a - 8'(d);
			end else begin
				b = a + 8'(d);
			end
			run_op(a, b, fpm_pkg::af);
			run_op(b, a, fpm_pkg::sf);
		end

		foreach (far_a[i]) begin
			run_op(far_a[i], far_b[i], fpm_pkg::af);
			run_op(far_b[i], far_a[i], fpm_pkg::sf);
		end

		// fixed-point group keeps exponent and shift
		for (int k = 0; k < 4; k++) begin
			run_op(8'($urandom), 8'($urandom), fpm_pkg::fpm_opcode_e'(k));
		end

		// second start while a long alignment runs
		start_op(8'h64, 8'h9c, fpm_pkg::af);
		exp = fpm_ref(last_cmd, model_result);
		reg_write(fpm_pkg::FPM_ADDR_CONTROL, {29'd0, fpm_pkg::mf}, 1'b1);
		check_operation(exp);
		model_result = exp;

		reg_read(4'h6, word, 1'b1);
		if (word !== 32'd0) begin
			stop_run($sformatf("MISMATCH prdata: got 0x%08h expected 0x00000000", word));
		end
		reg_write(4'h1, 32'hffff_ffff, 1'b1);

		// start on the stored operands, which the unmapped write must not touch
		reg_write(fpm_pkg::FPM_ADDR_CONTROL, {29'd0, fpm_pkg::mf}, 1'b0);
		last_cmd.op = fpm_pkg::mf;
		exp = fpm_ref(last_cmd, model_result);
		check_operation(exp);
		model_result = exp;

		$display("All checks passed");
		$finish;
	end

endmodule

// ==== flist.f ====
fpm_pkg.sv
fpm_opcode_decoder.sv
fpm_exponent_adder.sv
fpm_shift_counter.sv
fpm_sequencer.sv
fpm_apb_regs.sv
fpm_top.sv
tb_fpm.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_fpm
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= All checks passed
VFLAGS ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
